/* logic/rv_core_macros.svh */
// Integer core width defines
`ifndef RV_CORE_MACROS_SVH
`define RV_CORE_MACROS_SVH

// Data path width
`define RV_XLEN 32

// Architectural registers, x0 included
`define RV_REG_COUNT 32

// Register index width
`define RV_REG_AW 5

`endif

/* logic/rv_core_pkg.sv */
// Integer core shared types
`default_nettype none

package rv_core_pkg;

    // ALU operations carried from decode to execute
    typedef enum logic [3:0] {
        ALU_ADD    = 4'd0,
        ALU_SUB    = 4'd1,
        ALU_SLL    = 4'd2,
        ALU_SLT    = 4'd3,
        ALU_SLTU   = 4'd4,
        ALU_XOR    = 4'd5,
        ALU_SRL    = 4'd6,
        ALU_SRA    = 4'd7,
        ALU_OR     = 4'd8,
        ALU_AND    = 4'd9,
        ALU_PASS_B = 4'd10                          // LUI, result is operand b
    } alu_op_e;

    // Major opcodes
    localparam logic [6:0] OPC_OP     = 7'b0110011; // Register-register ALU
    localparam logic [6:0] OPC_OP_IMM = 7'b0010011; // Register-immediate ALU
    localparam logic [6:0] OPC_LUI    = 7'b0110111; // Load upper immediate

    // funct3 field of the ALU groups
    localparam logic [2:0] F3_ADD_SUB = 3'b000;
    localparam logic [2:0] F3_SLL     = 3'b001;
    localparam logic [2:0] F3_SLT     = 3'b010;
    localparam logic [2:0] F3_SLTU    = 3'b011;
    localparam logic [2:0] F3_XOR     = 3'b100;
    localparam logic [2:0] F3_SRL_SRA = 3'b101;
    localparam logic [2:0] F3_OR      = 3'b110;
    localparam logic [2:0] F3_AND     = 3'b111;

    // funct7 field, base and alternate (SUB, SRA)
    localparam logic [6:0] F7_BASE    = 7'b0000000;
    localparam logic [6:0] F7_ALT     = 7'b0100000;

endpackage

`default_nettype wire

/* logic/instr_decoder.sv */
// Instruction decode stage
`timescale 1ns/10ps
`default_nettype none
`include "rv_core_macros.svh"

module instr_decoder (
    input  logic                  clk,
    input  logic                  reset,
    input  logic                  instr_valid_i,
    input  logic [`RV_XLEN-1:0]   instr_i,
    output logic [`RV_REG_AW-1:0] rs1_o,
    output logic [`RV_REG_AW-1:0] rs2_o,
    output logic [`RV_REG_AW-1:0] rd_o,
    output rv_core_pkg::alu_op_e  alu_op_o,
    output logic                  use_imm_o,
    output logic [`RV_XLEN-1:0]   imm_o,
    output logic                  illegal_o,
    output logic                  valid_o
);

    logic [6:0]                opcode;
    logic [2:0]                funct3;
    logic [6:0]                funct7;
    logic [`RV_XLEN-1:0]       imm_i_type;                // Sign-extended I immediate
    logic [`RV_XLEN-1:0]       imm_shamt;                 // Zero-extended shift amount
    logic [`RV_XLEN-1:0]       imm_u_type;                // Upper immediate
    rv_core_pkg::alu_op_e      f3_op;                     // Operation selected by funct3
    rv_core_pkg::alu_op_e      nxt_op;
    logic                      nxt_use_imm;
    logic [`RV_XLEN-1:0]       nxt_imm;
    logic                      nxt_illegal;
    logic [`RV_REG_AW-1:0]     nxt_rs1;
    logic [`RV_REG_AW-1:0]     nxt_rs2;

    assign opcode     = instr_i[6:0];
    assign funct3     = instr_i[14:12];
    assign funct7     = instr_i[31:25];
    assign imm_i_type = {{(`RV_XLEN-12){instr_i[31]}}, instr_i[31:20]};
    assign imm_shamt  = {{(`RV_XLEN-5){1'b0}}, instr_i[24:20]};
    assign imm_u_type = {instr_i[31:12], 12'b0};

    // Base operation, shared by OP and OP-IMM
    always_comb begin
        case (funct3)
            rv_core_pkg::F3_ADD_SUB: f3_op = rv_core_pkg::ALU_ADD;
            rv_core_pkg::F3_SLL:     f3_op = rv_core_pkg::ALU_SLL;
            rv_core_pkg::F3_SLT:     f3_op = rv_core_pkg::ALU_SLT;
            rv_core_pkg::F3_SLTU:    f3_op = rv_core_pkg::ALU_SLTU;
            rv_core_pkg::F3_XOR:     f3_op = rv_core_pkg::ALU_XOR;
            rv_core_pkg::F3_SRL_SRA: f3_op = rv_core_pkg::ALU_SRL;
            rv_core_pkg::F3_OR:      f3_op = rv_core_pkg::ALU_OR;
            default:                 f3_op = rv_core_pkg::ALU_AND;
        endcase
    end

    always_comb begin
        nxt_op      = f3_op;
        nxt_use_imm = 1'b0;
        nxt_imm     = imm_i_type;
        nxt_illegal = 1'b0;
        nxt_rs1     = instr_i[19:15];
        nxt_rs2     = instr_i[24:20];
        case (opcode)
            rv_core_pkg::OPC_OP: begin
                if (funct7 == rv_core_pkg::F7_ALT) begin
                    if (funct3 == rv_core_pkg::F3_ADD_SUB) begin
                        nxt_op = rv_core_pkg::ALU_SUB;
                    end else if (funct3 == rv_core_pkg::F3_SRL_SRA) begin
                        nxt_op = rv_core_pkg::ALU_SRA;
                    end else begin
                        nxt_illegal = 1'b1;               // Alternate form only for SUB/SRA
                    end
                end else if (funct7 != rv_core_pkg::F7_BASE) begin
                    nxt_illegal = 1'b1;
                end
            end
            rv_core_pkg::OPC_OP_IMM: begin
                nxt_use_imm = 1'b1;
                nxt_rs2     = '0;                         // rs2 field is immediate here
                if (funct3 == rv_core_pkg::F3_SLL) begin
                    nxt_imm     = imm_shamt;
                    nxt_illegal = (funct7 != rv_core_pkg::F7_BASE);
                end else if (funct3 == rv_core_pkg::F3_SRL_SRA) begin
                    nxt_imm = imm_shamt;
                    if (funct7 == rv_core_pkg::F7_ALT) begin
                        nxt_op = rv_core_pkg::ALU_SRA;
                    end else if (funct7 != rv_core_pkg::F7_BASE) begin
                        nxt_illegal = 1'b1;               // Bad shift-immediate encoding
                    end
                end
            end
            rv_core_pkg::OPC_LUI: begin
                nxt_op      = rv_core_pkg::ALU_PASS_B;
                nxt_use_imm = 1'b1;
                nxt_imm     = imm_u_type;
                nxt_rs1     = '0;
                nxt_rs2     = '0;
            end
            default: begin
                nxt_op      = rv_core_pkg::ALU_ADD;
                nxt_illegal = 1'b1;                       // Unknown opcode
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            valid_o   <= 1'b0;
            illegal_o <= 1'b0;
        end else begin
            valid_o   <= instr_valid_i;
            illegal_o <= instr_valid_i & nxt_illegal;
        end
    end

    always_ff @(posedge clk) begin
        rs1_o     <= nxt_rs1;                             // Payload, no reset
        rs2_o     <= nxt_rs2;
        rd_o      <= instr_i[11:7];
        alu_op_o  <= nxt_op;
        use_imm_o <= nxt_use_imm;
        imm_o     <= nxt_imm;
    end

endmodule

`default_nettype wire

/* logic/regbank.sv */
// Integer register bank
`timescale 1ns/10ps
`default_nettype none
`include "rv_core_macros.svh"

module regbank (
    input  logic                  clk,
    input  logic                  reset,
    input  logic [`RV_REG_AW-1:0] rs1_i,
    input  logic [`RV_REG_AW-1:0] rs2_i,
    input  logic [`RV_REG_AW-1:0] rd_i,
    input  logic                  we_i,
    input  logic [`RV_XLEN-1:0]   data_i,
    output logic [`RV_XLEN-1:0]   data1_o,
    output logic [`RV_XLEN-1:0]   data2_o
);

    // x1..x31, x0 has no storage
    logic [`RV_XLEN-1:0] regs [1:`RV_REG_COUNT-1];

    // Asynchronous reads, index zero forced to zero
    assign data1_o = (rs1_i == '0) ? '0 : regs[rs1_i];
    assign data2_o = (rs2_i == '0) ? '0 : regs[rs2_i];

    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 1; i < `RV_REG_COUNT; i++) begin
                regs[i] <= '0;                            // Whole bank cleared
            end
        end else if (we_i && rd_i != '0) begin
            regs[rd_i] <= data_i;                         // Writes to x0 dropped
        end
    end

endmodule

`default_nettype wire

/* logic/operand_fetch.sv */
// Operand fetch and bypass stage
`timescale 1ns/10ps
`default_nettype none
`include "rv_core_macros.svh"

module operand_fetch (
    input  logic                  clk,
    input  logic                  reset,
    input  logic                  dec_valid_i,
    input  logic [`RV_REG_AW-1:0] dec_rs1_i,
    input  logic [`RV_REG_AW-1:0] dec_rs2_i,
    input  logic [`RV_REG_AW-1:0] dec_rd_i,
    input  rv_core_pkg::alu_op_e  dec_alu_op_i,
    input  logic                  dec_use_imm_i,
    input  logic [`RV_XLEN-1:0]   dec_imm_i,
    input  logic                  dec_illegal_i,
    input  logic [`RV_XLEN-1:0]   ex_result_i,
    input  logic                  wb_we_i,
    input  logic [`RV_REG_AW-1:0] wb_rd_i,
    input  logic [`RV_XLEN-1:0]   wb_data_i,
    output logic [`RV_REG_AW-1:0] rs1_o,
    output logic [`RV_REG_AW-1:0] rs2_o,
    input  logic [`RV_XLEN-1:0]   data1_i,
    input  logic [`RV_XLEN-1:0]   data2_i,
    output logic                  valid_o,
    output logic [`RV_REG_AW-1:0] rd_o,
    output rv_core_pkg::alu_op_e  alu_op_o,
    output logic [`RV_XLEN-1:0]   a_o,
    output logic [`RV_XLEN-1:0]   b_o,
    output logic                  illegal_o
);

    logic                ex_fwd;                          // Execute stage may forward
    logic [`RV_XLEN-1:0] src_a;
    logic [`RV_XLEN-1:0] src_b;

    // Picks the youngest valid producer of one source register
    function automatic logic [`RV_XLEN-1:0] bypass(
        input logic [`RV_REG_AW-1:0] idx,
        input logic [`RV_XLEN-1:0]   bank_data
    );
        logic [`RV_XLEN-1:0] val;
        if (idx == '0) begin
            val = '0;                                     // x0 always reads zero
        end else if (ex_fwd && rd_o == idx) begin
            val = ex_result_i;                            // Instruction in execute
        end else if (wb_we_i && wb_rd_i == idx) begin
            val = wb_data_i;                              // Retiring instruction
        end else begin
            val = bank_data;
        end
        return val;
    endfunction

    assign rs1_o  = dec_rs1_i;                            // Bank read indices
    assign rs2_o  = dec_rs2_i;
    assign ex_fwd = valid_o & ~illegal_o;

    assign src_a = bypass(dec_rs1_i, data1_i);
    assign src_b = dec_use_imm_i ? dec_imm_i : bypass(dec_rs2_i, data2_i);

    always_ff @(posedge clk) begin
        if (reset) begin
            valid_o   <= 1'b0;
            illegal_o <= 1'b0;
        end else begin
            valid_o   <= dec_valid_i;
            illegal_o <= dec_valid_i & dec_illegal_i;
        end
    end

    always_ff @(posedge clk) begin
        rd_o     <= dec_rd_i;
        alu_op_o <= dec_alu_op_i;
        a_o      <= src_a;
        b_o      <= src_b;
    end

endmodule

`default_nettype wire

/* logic/execute_unit.sv */
// ALU execute and retire stage
`timescale 1ns/10ps
`default_nettype none
`include "rv_core_macros.svh"

module execute_unit (
    input  logic                  clk,
    input  logic                  reset,
    input  logic                  valid_i,
    input  logic [`RV_REG_AW-1:0] rd_i,
    input  rv_core_pkg::alu_op_e  alu_op_i,
    input  logic [`RV_XLEN-1:0]   a_i,
    input  logic [`RV_XLEN-1:0]   b_i,
    input  logic                  illegal_i,
    output logic [`RV_XLEN-1:0]   result_o,
    output logic                  retire_valid_o,
    output logic [`RV_REG_AW-1:0] retire_rd_o,
    output logic [`RV_XLEN-1:0]   retire_data_o,
    output logic                  retire_illegal_o
);

    logic [4:0] shamt;                                    // Low 5 bits of operand b

    assign shamt = b_i[4:0];

    // Combinational result, also feeds the bypass path
    always_comb begin
        result_o = '0;
        case (alu_op_i)
            rv_core_pkg::ALU_ADD:    result_o = a_i + b_i;
            rv_core_pkg::ALU_SUB:    result_o = a_i - b_i;
            rv_core_pkg::ALU_SLL:    result_o = a_i << shamt;
            rv_core_pkg::ALU_SLT:    result_o[0] = $signed(a_i) < $signed(b_i);
            rv_core_pkg::ALU_SLTU:   result_o[0] = a_i < b_i;
            rv_core_pkg::ALU_XOR:    result_o = a_i ^ b_i;
            rv_core_pkg::ALU_SRL:    result_o = a_i >> shamt;
            rv_core_pkg::ALU_SRA:    result_o = $signed(a_i) >>> shamt;
            rv_core_pkg::ALU_OR:     result_o = a_i | b_i;
            rv_core_pkg::ALU_AND:    result_o = a_i & b_i;
            rv_core_pkg::ALU_PASS_B: result_o = b_i;      // LUI
            default:                 result_o = '0;
        endcase
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            retire_valid_o   <= 1'b0;
            retire_illegal_o <= 1'b0;
        end else begin
            retire_valid_o   <= valid_i;
            retire_illegal_o <= valid_i & illegal_i;
        end
    end

    always_ff @(posedge clk) begin
        retire_rd_o   <= rd_i;
        retire_data_o <= illegal_i ? '0 : result_o;       // Illegal retires with zero
    end

endmodule

`default_nettype wire

/* logic/int_pipeline_top.sv */
// Integer pipeline top level
`timescale 1ns/10ps
`default_nettype none
`include "rv_core_macros.svh"

module int_pipeline_top (
    input  logic                  clk,
    input  logic                  reset,
    input  logic                  instr_valid_i,
    input  logic [`RV_XLEN-1:0]   instr_i,
    output logic                  retire_valid_o,
    output logic [`RV_REG_AW-1:0] retire_rd_o,
    output logic [`RV_XLEN-1:0]   retire_data_o,
    output logic                  retire_illegal_o
);

    // Decode to operand fetch
    logic                  dec_valid;
    logic [`RV_REG_AW-1:0] dec_rs1;
    logic [`RV_REG_AW-1:0] dec_rs2;
    logic [`RV_REG_AW-1:0] dec_rd;
    rv_core_pkg::alu_op_e  dec_alu_op;
    logic                  dec_use_imm;
    logic [`RV_XLEN-1:0]   dec_imm;
    logic                  dec_illegal;

    // Operand fetch to execute
    logic                  opf_valid;
    logic [`RV_REG_AW-1:0] opf_rd;
    rv_core_pkg::alu_op_e  opf_alu_op;
    logic [`RV_XLEN-1:0]   opf_a;
    logic [`RV_XLEN-1:0]   opf_b;
    logic                  opf_illegal;

    logic [`RV_XLEN-1:0]   ex_result;                     // Bypass path 1
    logic                  wb_we;                         // Bank write enable
    logic [`RV_REG_AW-1:0] rf_rs1;
    logic [`RV_REG_AW-1:0] rf_rs2;
    logic [`RV_XLEN-1:0]   rf_data1;
    logic [`RV_XLEN-1:0]   rf_data2;

    assign wb_we = retire_valid_o & ~retire_illegal_o;    // Illegal never writes

    instr_decoder u_decoder (
        .clk           (clk),
        .reset         (reset),
        .instr_valid_i (instr_valid_i),
        .instr_i       (instr_i),
        .rs1_o         (dec_rs1),
        .rs2_o         (dec_rs2),
        .rd_o          (dec_rd),
        .alu_op_o      (dec_alu_op),
        .use_imm_o     (dec_use_imm),
        .imm_o         (dec_imm),
        .illegal_o     (dec_illegal),
        .valid_o       (dec_valid)
    );

    operand_fetch u_opfetch (
        .clk           (clk),
        .reset         (reset),
        .dec_valid_i   (dec_valid),
        .dec_rs1_i     (dec_rs1),
        .dec_rs2_i     (dec_rs2),
        .dec_rd_i      (dec_rd),
        .dec_alu_op_i  (dec_alu_op),
        .dec_use_imm_i (dec_use_imm),
        .dec_imm_i     (dec_imm),
        .dec_illegal_i (dec_illegal),
        .ex_result_i   (ex_result),
        .wb_we_i       (wb_we),                           // Bypass path 2
        .wb_rd_i       (retire_rd_o),
        .wb_data_i     (retire_data_o),
        .rs1_o         (rf_rs1),
        .rs2_o         (rf_rs2),
        .data1_i       (rf_data1),
        .data2_i       (rf_data2),
        .valid_o       (opf_valid),
        .rd_o          (opf_rd),
        .alu_op_o      (opf_alu_op),
        .a_o           (opf_a),
        .b_o           (opf_b),
        .illegal_o     (opf_illegal)
    );

    regbank u_regbank (
        .clk     (clk),
        .reset   (reset),
        .rs1_i   (rf_rs1),
        .rs2_i   (rf_rs2),
        .rd_i    (retire_rd_o),
        .we_i    (wb_we),
        .data_i  (retire_data_o),
        .data1_o (rf_data1),
        .data2_o (rf_data2)
    );

    execute_unit u_execute (
        .clk              (clk),
        .reset            (reset),
        .valid_i          (opf_valid),
        .rd_i             (opf_rd),
        .alu_op_i         (opf_alu_op),
        .a_i              (opf_a),
        .b_i              (opf_b),
        .illegal_i        (opf_illegal),
        .result_o         (ex_result),
        .retire_valid_o   (retire_valid_o),
        .retire_rd_o      (retire_rd_o),
        .retire_data_o    (retire_data_o),
        .retire_illegal_o (retire_illegal_o)
    );

endmodule

`default_nettype wire

/* verification/int_pipeline_checker.sv */
// Pipeline assertion checker
`timescale 1ns/10ps
`default_nettype none

module int_pipeline_checker (
    input logic clk,
    input logic reset,
    input logic instr_valid_i,
    input logic dec_illegal_i,
    input logic retire_valid_o,
    input logic retire_illegal_o,
    input logic wb_we
);

    int unsigned fail_count = 0;                          // Failed assertions so far

    // Pipeline empty on the edge after any reset cycle
    reset_idle: assert property (@(posedge clk) reset |=> (!retire_valid_o && !wb_we))
        else begin
            fail_count++;
            $error("retire or bank write active right after reset");
        end

    // Each accepted instruction retires exactly 3 edges later and only then
    fixed_latency: assert property (@(posedge clk) disable iff (reset)
        retire_valid_o == $past(instr_valid_i, 3))
        else begin
            fail_count++;
            $error("retire_valid_o does not match instr_valid_i three cycles earlier");
        end

    // A word flagged illegal at decode retires flagged and never reaches the bank
    illegal_no_write: assert property (@(posedge clk) disable iff (reset)
        $past(dec_illegal_i, 2) |-> (retire_illegal_o && !wb_we))
        else begin
            fail_count++;
            $error("illegal instruction did not retire flagged or enabled a bank write");
        end

endmodule

bind int_pipeline_top int_pipeline_checker u_checker (
    .clk              (clk),
    .reset            (reset),
    .instr_valid_i    (instr_valid_i),
    .dec_illegal_i    (dec_illegal),
    .retire_valid_o   (retire_valid_o),
    .retire_illegal_o (retire_illegal_o),
    .wb_we            (wb_we)
);

`default_nettype wire

/* verification/int_pipeline_tb.sv */
// Integer pipeline testbench
`timescale 1ns/10ps
`default_nettype none
`include "rv_core_macros.svh"

module int_pipeline_tb;

    localparam int NUM_CYCLES = 600;                      // Issue slots including idle ones

    logic                  clk;
    logic                  reset;
    logic                  instr_valid_i;
    logic [`RV_XLEN-1:0]   instr_i;
    logic                  retire_valid_o;
    logic [`RV_REG_AW-1:0] retire_rd_o;
    logic [`RV_XLEN-1:0]   retire_data_o;
    logic                  retire_illegal_o;

    integer                seed;
    int                    data_errors;
    int                    wait_cycles;
    logic                  drain_timeout;
    logic [`RV_XLEN-1:0]   next_instr;
    logic [37:0]           expected;                      // {illegal, rd, data}
    logic [37:0]           exp_q [$];                     // Retirements in program order
    logic [`RV_XLEN-1:0]   model_regs [`RV_REG_COUNT];

    int_pipeline_top u_dut (.*);

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;                            // 8 ns period
    end

    // Random word from OP, OP-IMM or LUI or an illegal one over registers x0 to x7
    function automatic logic [`RV_XLEN-1:0] random_instr();
        logic [31:0] w;
        logic [2:0]  f3;
        int          kind;
        w        = $random(seed);
        kind     = {$random(seed)} % 20;
        f3       = w[14:12];
        w[11:10] = 2'b00;                                 // rd
        w[19:18] = 2'b00;                                 // rs1
        if (kind == 0) begin
            if (w[6:0] == rv_core_pkg::OPC_OP || w[6:0] == rv_core_pkg::OPC_OP_IMM ||
                w[6:0] == rv_core_pkg::OPC_LUI) begin
                w[6] = 1'b1;                              // Push to an unsupported opcode
            end
        end else if (kind == 1) begin
            w[31:25] = 7'b0000001;                        // Bad funct7
            if (w[13]) begin
                w[6:0] = rv_core_pkg::OPC_OP;
            end else begin
                w[6:0] = rv_core_pkg::OPC_OP_IMM;
                w[12]  = 1'b1;                            // Shift-immediate encoding
            end
        end else if (kind < 9) begin
            w[6:0]   = rv_core_pkg::OPC_OP;
            w[24:23] = 2'b00;                             // rs2
            w[31:25] = {1'b0, w[30] & (f3 == 3'd0 || f3 == 3'd5), 5'b0};
        end else if (kind < 17) begin
            w[6:0] = rv_core_pkg::OPC_OP_IMM;
            if (f3 == 3'd1) begin
                w[31:25] = 7'b0;                          // SLLI
            end else if (f3 == 3'd5) begin
                w[31:25] = {1'b0, w[30], 5'b0};           // SRLI or SRAI
            end
        end else begin
            w[6:0] = rv_core_pkg::OPC_LUI;
        end
        return w;
    endfunction

    // Reference result from the ISA rules in program order
    task automatic model_instr(input logic [`RV_XLEN-1:0] instr);
        logic [6:0]  opc;
        logic [2:0]  f3;
        logic        alt;
        logic        ill;
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] res;
        opc = instr[6:0];
        f3  = instr[14:12];
        alt = (instr[31:25] == 7'b0100000);
        a   = model_regs[instr[19:15]];
        b   = (opc == rv_core_pkg::OPC_OP) ? model_regs[instr[24:20]]
                                           : {{20{instr[31]}}, instr[31:20]};
        if (opc == rv_core_pkg::OPC_OP) begin
            ill = !(instr[31:25] == 7'b0 || (alt && (f3 == 3'd0 || f3 == 3'd5)));
        end else if (opc == rv_core_pkg::OPC_OP_IMM) begin
            ill = (f3 == 3'd1 && instr[31:25] != 7'b0) ||
                  (f3 == 3'd5 && instr[31:25] != 7'b0 && !alt);
        end else begin
            ill = (opc != rv_core_pkg::OPC_LUI);
        end
        case (f3)
            3'd0:    res = (opc == rv_core_pkg::OPC_OP && alt) ? a - b : a + b;
            3'd1:    res = a << b[4:0];
            3'd2:    res = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
            3'd3:    res = (a < b) ? 32'd1 : 32'd0;      // Unsigned compare to sign-extended imm
            3'd4:    res = a ^ b;
            3'd5:    res = alt ? 32'($signed(a) >>> b[4:0]) : a >> b[4:0];
            3'd6:    res = a | b;
            default: res = a & b;
        endcase
        if (opc == rv_core_pkg::OPC_LUI) begin
            res = {instr[31:12], 12'b0};
        end
        if (ill) begin
            res = '0;
        end else if (instr[11:7] != 5'd0) begin
            model_regs[instr[11:7]] = res;                // x0 never written
        end
        exp_q.push_back({ill, instr[11:7], res});
    endtask

    task automatic check_field(input string name, input logic [31:0] exp_val,
                               input logic [31:0] act_val);
        assert (act_val == exp_val) else begin
            data_errors++;
            $display("[ERROR] %s: expected %h, actual %h", name, exp_val, act_val);
        end
    endtask

    // Retire outputs compared on the falling edge where they are settled
    always @(negedge clk) begin
        if (!reset && retire_valid_o) begin
            assert (exp_q.size() != 0) else begin
                data_errors++;
                $display("A retirement appeared with no instruction outstanding");
            end
            if (exp_q.size() != 0) begin
                expected = exp_q.pop_front();
                check_field("retire_illegal", {31'b0, expected[37]}, {31'b0, retire_illegal_o});
                check_field("retire_rd", {27'b0, expected[36:32]}, {27'b0, retire_rd_o});
                check_field("retire_data", expected[31:0], retire_data_o);
            end
        end
    end

    initial begin
        reset         = 1'b1;
        instr_valid_i = 1'b0;
        instr_i       = '0;
        seed          = 77;
        data_errors   = 0;
        drain_timeout = 1'b0;
        for (int i = 0; i < `RV_REG_COUNT; i++) begin
            model_regs[i] = '0;                           // Bank starts cleared
        end
        repeat (5) @(posedge clk);
        reset <= 1'b0;
        repeat (4) @(posedge clk);                        // Idle cycles with nothing to retire
        for (int n = 0; n < NUM_CYCLES; n++) begin
            @(posedge clk);
            if ({$random(seed)} % 5 == 0) begin
                instr_valid_i <= 1'b0;                    // Gap
            end else begin
                next_instr = random_instr();
                instr_valid_i <= 1'b1;
                instr_i       <= next_instr;
                model_instr(next_instr);
            end
        end
        @(posedge clk);
        instr_valid_i <= 1'b0;
        wait_cycles = 0;
        while (exp_q.size() != 0 && wait_cycles < 20) begin
            @(posedge clk);
            wait_cycles++;
        end
        if (exp_q.size() != 0) begin
            drain_timeout = 1'b1;
            $display("Timeout: %0d instructions never retired", exp_q.size());
        end
        repeat (2) @(posedge clk);
        $display("Errors: data %0d, assertions %0d, timeout %0d", data_errors,
                 u_dut.u_checker.fail_count, drain_timeout);
        if (data_errors == 0 && u_dut.u_checker.fail_count == 0 && !drain_timeout) begin
            $display("Everything OK");
        end else begin
            $display("Something failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* vlog.f */
+incdir+logic
logic/rv_core_pkg.sv
logic/instr_decoder.sv
logic/regbank.sv
logic/operand_fetch.sv
logic/execute_unit.sv
logic/int_pipeline_top.sv
verification/int_pipeline_checker.sv
verification/int_pipeline_tb.sv

/* run_sim.sh */
#!/usr/bin/env bash
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --top-module int_pipeline_tb -f vlog.f -o int_pipeline_sim

status=0
output=$(./obj_dir/int_pipeline_sim +verilator+error+limit+1000 2>&1) || status=$?
echo "$output"

if [ "$status" -eq 0 ] && grep -qx "Everything OK" <<< "$output"; then
    exit 0
fi
exit 1
